// ==== hw/pdes_pkg.sv ====
package pdes_pkg;

   // event field widths
   localparam int TIME_WID  = 16;
   localparam int LP_WID    = 8;
   localparam int EVENT_WID = LP_WID + TIME_WID;

   // run statistics and init count
   localparam int STAT_WID = 32;
   localparam int INIT_WID = 9;

   typedef logic [TIME_WID-1:0]  sim_time_t;
   typedef logic [LP_WID-1:0]    lp_id_t;

   // target lp in the upper bits, timestamp in the lower bits
   typedef logic [EVENT_WID-1:0] event_t;

   typedef logic [STAT_WID-1:0]  stat_t;
   typedef logic [INIT_WID-1:0]  init_count_t;

   // scheduler run phases
   typedef enum logic [1:0] {
      IDLE,
      INIT,
      RUNNING,
      FINISHED
   } run_state_t;

endpackage

// ==== hw/rr_arbiter.sv ====
module rr_arbiter #(
   parameter int NR = 4,
   localparam int IDX_WID = (NR > 1) ? $clog2(NR) : 1
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [NR-1:0]      req,
   input  logic               advance,
   output logic               gnt_vld,
   output logic [IDX_WID-1:0] gnt_idx
);

   // index of the last requester that won
   logic [IDX_WID-1:0] last_win;

   // walk from the farthest slot back to the nearest, nearest wins
   always_comb begin : grant_search
      int unsigned cand;
      gnt_vld = 1'b0;
      gnt_idx = '0;
      for (int k = NR; k >= 1; k--) begin
         cand = (int'(last_win) + k) % NR;
         if (req[cand]) begin
            gnt_vld = 1'b1;
            gnt_idx = IDX_WID'(cand);
         end
      end
   end

   // start so that slot 0 has first priority
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         last_win <= IDX_WID'(NR - 1);
      else if (advance && gnt_vld)
         last_win <= gnt_idx;
   end

endmodule

// ==== hw/event_queue.sv ====
module event_queue #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             enq,
   input  pdes_pkg::event_t enq_event,
   input  logic             deq,
   output pdes_pkg::event_t head,
   output logic             empty,
   output logic             full
);

   localparam int CNT_WID = $clog2(QUEUE_DEPTH + 1);
   localparam int T       = pdes_pkg::TIME_WID;

   pdes_pkg::event_t   mem     [QUEUE_DEPTH];
   pdes_pkg::event_t   shifted [QUEUE_DEPTH];
   pdes_pkg::event_t   nxt     [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] keep;
   logic [CNT_WID-1:0] count;
   logic [CNT_WID-1:0] cnt_shift;
   logic [CNT_WID-1:0] cnt_next;

   assign head = mem[0];

   // deq first, then insert behind all entries with time <= new time
   always_comb begin
      cnt_shift = deq ? count - 1'b1 : count;
      shifted[QUEUE_DEPTH-1] = mem[QUEUE_DEPTH-1];
      for (int i = 0; i < QUEUE_DEPTH - 1; i++)
         shifted[i] = deq ? mem[i+1] : mem[i];
      for (int i = 0; i < QUEUE_DEPTH; i++)
         keep[i] = (CNT_WID'(i) < cnt_shift) && (shifted[i][T-1:0] <= enq_event[T-1:0]);
      nxt[0] = keep[0] ? shifted[0] : enq_event;
      for (int i = 1; i < QUEUE_DEPTH; i++)
         nxt[i] = keep[i] ? shifted[i] : (keep[i-1] ? enq_event : shifted[i-1]);
   end

   assign cnt_next = count + CNT_WID'(enq) - CNT_WID'(deq);

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++)
         mem[i] <= enq ? nxt[i] : shifted[i];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
         empty <= 1'b1;
         full  <= 1'b0;
      end else begin
         count <= cnt_next;
         empty <= (cnt_next == '0);
         full  <= (cnt_next == CNT_WID'(QUEUE_DEPTH));
      end
   end

   a_no_enq_full  : assert property (@(posedge clk) disable iff (!rst_n) enq |-> !full);
   a_no_deq_empty : assert property (@(posedge clk) disable iff (!rst_n) deq |-> !empty);

endmodule

// ==== hw/gvt_tracker.sv ====
module gvt_tracker #(
   parameter int NUM_CORE = 4,
   localparam int IDX_WID = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pdes_pkg::run_state_t state,
   input  logic                 disp_strobe,
   input  logic [IDX_WID-1:0]   disp_core,
   input  pdes_pkg::sim_time_t  head_time,
   input  logic                 empty,
   input  logic [IDX_WID-1:0]   ack_core,
   input  logic                 ack_strobe,
   output logic [NUM_CORE-1:0]  core_busy,
   output pdes_pkg::sim_time_t  busy_min,
   output logic                 any_busy,
   output pdes_pkg::sim_time_t  gvt
);

   pdes_pkg::sim_time_t held_time [NUM_CORE];
   pdes_pkg::sim_time_t q_min;
   pdes_pkg::sim_time_t gvt_cand;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         core_busy <= '0;
      end else begin
         if (ack_strobe)
            core_busy[ack_core] <= 1'b0;
         if (disp_strobe)
            core_busy[disp_core] <= 1'b1;
      end
   end

   // timestamp of the event each core is working on
   always_ff @(posedge clk) begin
      if (disp_strobe)
         held_time[disp_core] <= head_time;
   end

   always_comb begin
      busy_min = '1;
      for (int c = 0; c < NUM_CORE; c++) begin
         if (core_busy[c] && held_time[c] < busy_min)
            busy_min = held_time[c];
      end
   end

   assign any_busy = |core_busy;
   assign q_min    = empty ? '1 : head_time;
   assign gvt_cand = (q_min < busy_min) ? q_min : busy_min;

   // all ones on both sides means no information, keep the old value
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         gvt <= '0;
      else if (state == pdes_pkg::INIT)
         gvt <= '0;
      else if ((state == pdes_pkg::RUNNING || state == pdes_pkg::FINISHED) && !(&gvt_cand))
         gvt <= gvt_cand;
   end

   a_disp_idle_core : assert property (
      @(posedge clk) disable iff (!rst_n) disp_strobe |-> !core_busy[disp_core]);
   a_ack_busy_core : assert property (
      @(posedge clk) disable iff (!rst_n) ack_strobe |-> core_busy[ack_core]);
   a_gvt_monotonic : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state inside {pdes_pkg::RUNNING, pdes_pkg::FINISHED}) &&
      ($past(state) inside {pdes_pkg::RUNNING, pdes_pkg::FINISHED}) |-> gvt >= $past(gvt));

endmodule

// ==== hw/event_router.sv ====
module event_router #(
   parameter int NUM_CORE = 4,
   localparam int IDX_WID = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  pdes_pkg::run_state_t                    state,
   input  logic                                    init_vld,
   input  pdes_pkg::event_t                        init_event,
   input  logic [NUM_CORE-1:0]                     core_ready,
   input  logic [NUM_CORE-1:0]                     ret_vld,
   input  logic [NUM_CORE*pdes_pkg::EVENT_WID-1:0] ret_event,
   input  logic [NUM_CORE-1:0]                     core_busy,
   input  pdes_pkg::sim_time_t                     busy_min,
   input  pdes_pkg::sim_time_t                     sim_end,
   input  pdes_pkg::event_t                        head,
   input  logic                                    empty,
   input  logic                                    full,
   output logic                                    enq,
   output pdes_pkg::event_t                        enq_event,
   output logic                                    deq,
   output logic [NUM_CORE-1:0]                     disp_vld,
   output pdes_pkg::event_t                        disp_event,
   output logic [NUM_CORE-1:0]                     ret_ack,
   output logic                                    disp_strobe,
   output logic [IDX_WID-1:0]                      disp_core,
   output logic [IDX_WID-1:0]                      ack_core
);

   logic                rcv_vld;
   logic [IDX_WID-1:0]  rcv_idx;
   logic                send_vld;
   logic [IDX_WID-1:0]  send_idx;
   logic                ret_take;
   logic                disp_go;
   logic                flush;
   pdes_pkg::sim_time_t head_time;

   assign head_time = head[pdes_pkg::TIME_WID-1:0];

   rr_arbiter #(.NR(NUM_CORE)) rcv_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (ret_vld),
      .advance (ret_take),
      .gnt_vld (rcv_vld),
      .gnt_idx (rcv_idx)
   );

   // only idle cores that say they are available
   rr_arbiter #(.NR(NUM_CORE)) send_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_ready & ~core_busy),
      .advance (disp_go),
      .gnt_vld (send_vld),
      .gnt_idx (send_idx)
   );

   // full queue holds the return back until space frees up
   assign ret_take = (state == pdes_pkg::RUNNING) && rcv_vld && !full;
   assign ret_ack  = ret_take ? (NUM_CORE'(1) << rcv_idx) : '0;
   assign ack_core = rcv_idx;

   assign enq       = (state == pdes_pkg::INIT) ? init_vld : ret_take;
   assign enq_event = (state == pdes_pkg::INIT) ? init_event :
                      ret_event[rcv_idx*pdes_pkg::EVENT_WID +: pdes_pkg::EVENT_WID];

   // conservative: head may not overtake any event still on a core
   assign disp_go = (state == pdes_pkg::RUNNING) && !empty && send_vld &&
                    (head_time <= sim_end) && (head_time <= busy_min);

   // leftovers of the last run are dropped while init_vld is held back
   assign flush = (state == pdes_pkg::INIT) && !init_vld && !empty;

   assign deq         = disp_go || flush;
   assign disp_strobe = disp_go;
   assign disp_core   = send_idx;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         disp_vld <= '0;
      else
         disp_vld <= disp_go ? (NUM_CORE'(1) << send_idx) : '0;
   end

   always_ff @(posedge clk) begin
      if (disp_go)
         disp_event <= head;
   end

   a_disp_ready_core : assert property (
      @(posedge clk) disable iff (!rst_n) disp_go |-> core_ready[send_idx]);

endmodule

// ==== hw/sched_ctrl.sv ====
module sched_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  pdes_pkg::init_count_t num_init_events,
   input  pdes_pkg::lp_id_t      lp_mask,
   input  pdes_pkg::sim_time_t   sim_end,
   input  pdes_pkg::event_t      head,
   input  logic                  empty,
   input  logic                  any_busy,
   input  logic                  deq,
   output pdes_pkg::run_state_t  state,
   output logic                  init_vld,
   output pdes_pkg::event_t      init_event,
   output logic                  running,
   output logic                  done,
   output pdes_pkg::stat_t       total_cycles,
   output pdes_pkg::stat_t       total_events
);

   pdes_pkg::init_count_t init_cnt;
   pdes_pkg::init_count_t init_next;
   logic                  init_last;
   logic                  run_over;
   logic                  flushing;

   // events left over from the previous run leave the queue before the first insert
   assign flushing  = (init_cnt == '0) && !empty;
   assign init_next = init_cnt + 1'b1;
   assign init_last = (init_next >= num_init_events);
   assign init_vld  = (state == pdes_pkg::INIT) && !flushing && (init_cnt < num_init_events);

   // initial event i goes to lp (i & lp_mask) at time zero
   assign init_event = {init_cnt[pdes_pkg::LP_WID-1:0] & lp_mask,
                        {pdes_pkg::TIME_WID{1'b0}}};

   // nothing in flight and nothing left at or before sim_end
   assign run_over = !any_busy && (empty || (head[pdes_pkg::TIME_WID-1:0] > sim_end));

   assign running = (state == pdes_pkg::RUNNING);
   assign done    = (state == pdes_pkg::FINISHED);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= pdes_pkg::IDLE;
         init_cnt <= '0;
      end else begin
         case (state)
            pdes_pkg::IDLE: begin
               init_cnt <= '0;
               if (start)
                  state <= pdes_pkg::INIT;
            end
            pdes_pkg::INIT: begin
               if (!flushing) begin
                  init_cnt <= init_next;
                  if (init_last)
                     state <= pdes_pkg::RUNNING;
               end
            end
            pdes_pkg::RUNNING: begin
               if (run_over)
                  state <= pdes_pkg::FINISHED;
            end
            default: state <= pdes_pkg::IDLE;
         endcase
      end
   end

   // statistics, held from done until the next start
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_cycles <= '0;
         total_events <= '0;
      end else if (state == pdes_pkg::IDLE && start) begin
         total_cycles <= '0;
         total_events <= '0;
      end else begin
         if (state == pdes_pkg::RUNNING)
            total_cycles <= total_cycles + 1'b1;
         // only dispatches count, not the flush in INIT
         if (deq && state == pdes_pkg::RUNNING)
            total_events <= total_events + 1'b1;
      end
   end

   a_init_cores_idle : assert property (
      @(posedge clk) disable iff (!rst_n) init_vld |-> !any_busy);

endmodule

// ==== hw/pdes_scheduler.sv ====
module pdes_scheduler #(
   parameter int NUM_CORE    = 4,
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  start,
   input  pdes_pkg::init_count_t                 num_init_events,
   input  pdes_pkg::lp_id_t                      lp_mask,
   input  pdes_pkg::sim_time_t                   sim_end,
   input  logic [NUM_CORE-1:0]                   core_ready,
   input  logic [NUM_CORE-1:0]                   ret_vld,
   input  logic [NUM_CORE*pdes_pkg::EVENT_WID-1:0] ret_event,
   output logic [NUM_CORE-1:0]                   disp_vld,
   output pdes_pkg::event_t                      disp_event,
   output logic [NUM_CORE-1:0]                   ret_ack,
   output pdes_pkg::sim_time_t                   gvt,
   output logic                                  running,
   output logic                                  done,
   output pdes_pkg::stat_t                       total_cycles,
   output pdes_pkg::stat_t                       total_events
);

   localparam int IDX_WID = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

   pdes_pkg::run_state_t state;
   logic                 init_vld;
   pdes_pkg::event_t     init_event;

   // queue side
   logic                 enq;
   logic                 deq;
   pdes_pkg::event_t     enq_event;
   pdes_pkg::event_t     head;
   logic                 empty;
   logic                 full;

   // core occupancy
   logic [NUM_CORE-1:0]  core_busy;
   pdes_pkg::sim_time_t  busy_min;
   logic                 any_busy;
   logic                 disp_strobe;
   logic [IDX_WID-1:0]   disp_core;
   logic [IDX_WID-1:0]   ack_core;

   sched_ctrl i_sched_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .sim_end         (sim_end),
      .head            (head),
      .empty           (empty),
      .any_busy        (any_busy),
      .deq             (deq),
      .state           (state),
      .init_vld        (init_vld),
      .init_event      (init_event),
      .running         (running),
      .done            (done),
      .total_cycles    (total_cycles),
      .total_events    (total_events)
   );

   event_router #(
      .NUM_CORE (NUM_CORE)
   ) i_event_router (
      .clk         (clk),
      .rst_n       (rst_n),
      .state       (state),
      .init_vld    (init_vld),
      .init_event  (init_event),
      .core_ready  (core_ready),
      .ret_vld     (ret_vld),
      .ret_event   (ret_event),
      .core_busy   (core_busy),
      .busy_min    (busy_min),
      .sim_end     (sim_end),
      .head        (head),
      .empty       (empty),
      .full        (full),
      .enq         (enq),
      .enq_event   (enq_event),
      .deq         (deq),
      .disp_vld    (disp_vld),
      .disp_event  (disp_event),
      .ret_ack     (ret_ack),
      .disp_strobe (disp_strobe),
      .disp_core   (disp_core),
      .ack_core    (ack_core)
   );

   event_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_event_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .enq       (enq),
      .enq_event (enq_event),
      .deq       (deq),
      .head      (head),
      .empty     (empty),
      .full      (full)
   );

   // a return is acknowledged exactly when some ret_ack bit is high
   gvt_tracker #(
      .NUM_CORE (NUM_CORE)
   ) i_gvt_tracker (
      .clk         (clk),
      .rst_n       (rst_n),
      .state       (state),
      .disp_strobe (disp_strobe),
      .disp_core   (disp_core),
      .head_time   (head[pdes_pkg::TIME_WID-1:0]),
      .empty       (empty),
      .ack_core    (ack_core),
      .ack_strobe  (|ret_ack),
      .core_busy   (core_busy),
      .busy_min    (busy_min),
      .any_busy    (any_busy),
      .gvt         (gvt)
   );

endmodule

// ==== dv/tb_pdes_scheduler.sv ====
module tb_pdes_scheduler;

   localparam int NUM_CORE    = 4;
   localparam int QUEUE_DEPTH = 16;
   localparam int NUM_ROWS    = 5;
   localparam int EW          = pdes_pkg::EVENT_WID;
   localparam int TW          = pdes_pkg::TIME_WID;

   logic                        clk;
   logic                        rst_n;
   logic                        start;
   pdes_pkg::init_count_t       num_init_events;
   pdes_pkg::lp_id_t            lp_mask;
   pdes_pkg::sim_time_t         sim_end;
   logic [NUM_CORE-1:0]         core_ready;
   logic [NUM_CORE-1:0]         ret_vld;
   logic [NUM_CORE*EW-1:0]      ret_event;
   logic [NUM_CORE-1:0]         disp_vld;
   pdes_pkg::event_t            disp_event;
   logic [NUM_CORE-1:0]         ret_ack;
   pdes_pkg::sim_time_t         gvt;
   logic                        running;
   logic                        done;
   pdes_pkg::stat_t             total_cycles;
   pdes_pkg::stat_t             total_events;

   // stimulus columns; expected columns are filled in by walk_chains
   int                  tbl_n     [NUM_ROWS] = '{4, 9, 16, 1, 12};
   int                  tbl_mask  [NUM_ROWS] = '{3, 7, 15, 0, 3};
   int                  tbl_end   [NUM_ROWS] = '{40, 100, 60, 30, 0};
   logic [NUM_CORE-1:0] tbl_ready [NUM_ROWS] = '{4'b1111, 4'b1111, 4'b1011, 4'b1111, 4'b1111};
   int                  exp_cnt   [NUM_ROWS];
   int                  exp_end   [NUM_ROWS];

   // time step of a child event, indexed by the parent lp
   int hop [16] = '{3, 1, 4, 1, 5, 2, 6, 7, 2, 3, 5, 4, 6, 1, 7, 2};

   integer seed       = 81;
   int     limit      = 0;
   int     cycle_cnt  = 0;
   int     disp_count = 0;
   int     done_count = 0;
   int     last_disp  = 0;
   int     prev_gvt   = 0;

   pdes_scheduler #(
      .NUM_CORE    (NUM_CORE),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_pdes_scheduler (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .sim_end         (sim_end),
      .core_ready      (core_ready),
      .ret_vld         (ret_vld),
      .ret_event       (ret_event),
      .disp_vld        (disp_vld),
      .disp_event      (disp_event),
      .ret_ack         (ret_ack),
      .gvt             (gvt),
      .running         (running),
      .done            (done),
      .total_cycles    (total_cycles),
      .total_events    (total_events)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "check failed");
      end
   endtask

   // follow each initial chain until its time passes sim_end
   task automatic walk_chains(input int n, input int mask, input int s_end,
                              output int cnt, output int end_t);
      int lp;
      int t;
      cnt   = 0;
      end_t = 65535;
      for (int i = 0; i < n; i++) begin
         lp = i & mask;
         t  = 0;
         while (t <= s_end) begin
            cnt++;
            t  = t + hop[lp[3:0]];
            lp = (lp + 1) & mask;
         end
         if (t < end_t)
            end_t = t;
      end
   endtask

   task automatic apply_row(input int r);
      int gvt_end;
      @(posedge clk);
      #1;
      num_init_events = pdes_pkg::init_count_t'(tbl_n[r]);
      lp_mask         = pdes_pkg::lp_id_t'(tbl_mask[r]);
      sim_end         = pdes_pkg::sim_time_t'(tbl_end[r]);
      core_ready      = tbl_ready[r];
      start           = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      @(posedge clk);
      while (done !== 1'b1)
         @(posedge clk);
      gvt_end = (exp_end[r] == 65535) ? last_disp : exp_end[r];
      expect_equal("total_events", total_events, exp_cnt[r]);
      expect_equal("total_events vs disp_vld pulses", total_events, disp_count);
      expect_equal("total_cycles >= total_events", 32'(total_cycles >= total_events), 1);
      expect_equal("running at done", 32'(running), 0);
      expect_equal("gvt at done", 32'(gvt), gvt_end);
      repeat (3) @(posedge clk);
      expect_equal("done pulse count", done_count, r + 1);
      expect_equal("done after run", 32'(done), 0);
      expect_equal("running after run", 32'(running), 0);
      expect_equal("gvt after run", 32'(gvt), gvt_end);
   endtask

   // behavioral cores: random work time, then one child event back
   initial begin : core_models
      int                  phase     [NUM_CORE];
      int                  wait_left [NUM_CORE];
      pdes_pkg::event_t    held      [NUM_CORE];
      logic [NUM_CORE-1:0] ack_s;
      logic [NUM_CORE-1:0] vld_s;
      pdes_pkg::event_t    ev_s;
      pdes_pkg::lp_id_t    plp;
      pdes_pkg::sim_time_t ptime;
      ret_vld   = '0;
      ret_event = '0;
      for (int c = 0; c < NUM_CORE; c++) begin
         phase[c]     = 0;
         wait_left[c] = 0;
         held[c]      = '0;
      end
      forever begin
         @(posedge clk);
         ack_s = ret_ack;
         vld_s = disp_vld;
         ev_s  = disp_event;
         #1;
         for (int c = 0; c < NUM_CORE; c++) begin
            // 0 idle, 1 working, 2 waiting for ack
            if (phase[c] == 2 && ack_s[c]) begin
               ret_vld[c] = 1'b0;
               phase[c]   = 0;
            end
            if (vld_s[c]) begin
               held[c]      = ev_s;
               wait_left[c] = 1 + int'({$random(seed)} % 6);
               phase[c]     = 1;
            end else if (phase[c] == 1) begin
               wait_left[c]--;
               if (wait_left[c] == 0) begin
                  plp   = held[c][EW-1:TW];
                  ptime = held[c][TW-1:0];
                  ret_event[c*EW +: EW] = {(plp + 8'd1) & lp_mask,
                                           ptime + 16'(hop[plp[3:0]])};
                  ret_vld[c] = 1'b1;
                  phase[c]   = 2;
               end
            end
         end
      end
   end

   always @(posedge clk) begin : monitor
      int t;
      int lp;
      if (rst_n) begin
         cycle_cnt++;
         if (cycle_cnt > limit) begin
            $display("Timeout: runs did not complete within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
         end
         if (start) begin
            disp_count = 0;
            last_disp  = 0;
            prev_gvt   = 0;
         end
         if (disp_vld != '0) begin
            t  = int'(disp_event[TW-1:0]);
            lp = int'(disp_event[EW-1:TW]);
            // initial events come out first, in order
            if (disp_count < int'(num_init_events)) begin
               expect_equal("disp_event lp", lp, disp_count & int'(lp_mask));
               expect_equal("disp_event time", t, 0);
            end
            expect_equal("disp time <= sim_end", 32'(t <= int'(sim_end)), 1);
            expect_equal("disp time non-decreasing", 32'(t >= last_disp), 1);
            expect_equal("disp time >= earlier gvt", 32'(t >= prev_gvt), 1);
            last_disp = t;
            disp_count++;
         end
         expect_equal("disp_vld to core not ready", 32'(disp_vld & ~core_ready), 0);
         if (running || done) begin
            expect_equal("gvt non-decreasing", 32'(int'(gvt) >= prev_gvt), 1);
            prev_gvt = int'(gvt);
         end
         if (done)
            done_count++;
      end
   end

   initial begin : stimulus
      int cnt;
      int end_t;
      limit = 20;
      for (int r = 0; r < NUM_ROWS; r++) begin
         walk_chains(tbl_n[r], tbl_mask[r], tbl_end[r], cnt, end_t);
         exp_cnt[r] = cnt;
         exp_end[r] = end_t;
         limit      = limit + (cnt + tbl_n[r]) * 10 + 100;
      end
      rst_n           = 1'b0;
      start           = 1'b0;
      num_init_events = '0;
      lp_mask         = '0;
      sim_end         = '0;
      core_ready      = '0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      expect_equal("disp_vld after reset", 32'(disp_vld), 0);
      expect_equal("ret_ack after reset", 32'(ret_ack), 0);
      expect_equal("running after reset", 32'(running), 0);
      expect_equal("done after reset", 32'(done), 0);
      expect_equal("gvt after reset", 32'(gvt), 0);
      for (int r = 0; r < NUM_ROWS; r++)
         apply_row(r);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== build.f ====
hw/pdes_pkg.sv
hw/rr_arbiter.sv
hw/event_queue.sv
hw/gvt_tracker.sv
hw/event_router.sv
hw/sched_ctrl.sv
hw/pdes_scheduler.sv
dv/tb_pdes_scheduler.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pdes_scheduler
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
